// ==== sources.f ====
source/dtm_pkg.sv
source/tap5_fsm.sv
source/tap2_field_regs.sv
source/tap2_ctrl.sv
source/dtm_ctrl.sv
verif/tb_dtm_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the debug transport control testbench with Verilator and run it

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sources.f --top-module tb_dtm_ctrl -o sim_dtm_ctrl \
    || { echo "build failed"; exit 1; }

./obj_dir/sim_dtm_ctrl | tee /dev/stderr | grep -q "^TESTS PASSED$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== verif/tb_dtm_ctrl.sv ====
// ========================================
// Testbench for the debug transport control
// Random four-wire and two-wire traffic
// checked against a cycle model
// ========================================
`timescale 1ns/1ps

module tb_dtm_ctrl;

    localparam int T_CLK   = 100;
    localparam int N_WALK  = 2000;
    localparam int N_PKT   = 40;
    localparam int PKT_MAX = 64;     // Longest packet with its idle bit
    localparam int WD_CYC  = (10 + N_WALK + 40 + (7 * N_PKT / 2) * PKT_MAX) * 12 / 10;

    // TAP step inside the DR or IR column, REST is reset or idle
    localparam logic [2:0] S_SEL   = 3'd0;
    localparam logic [2:0] S_CAP   = 3'd1;
    localparam logic [2:0] S_SHIFT = 3'd2;
    localparam logic [2:0] S_EX1   = 3'd3;
    localparam logic [2:0] S_PAUSE = 3'd4;
    localparam logic [2:0] S_EX2   = 3'd5;
    localparam logic [2:0] S_UPD   = 3'd6;
    localparam logic [2:0] S_REST  = 3'd7;

    // Two-wire packet fields
    localparam int P_RESET  = 0;
    localparam int P_START  = 1;
    localparam int P_RW     = 2;
    localparam int P_RS     = 3;
    localparam int P_TRN1   = 4;
    localparam int P_SYNC   = 5;
    localparam int P_DATA   = 6;
    localparam int P_PARITY = 7;
    localparam int P_TRN2   = 8;

    logic tclk, trst_b;
    logic dmi_hard_reset_i, tap_en_i, jtag2_sel_i, tms_i, dmi_short_i;
    logic tdo_en_o, tms_oe_o;
    logic capture_ir_o, capture_dr_o, shift_ir_o, shift_dr_o;
    logic update_ir_o, update_dr_o, shift_par_o, shift_sync_o;

    logic        p_tms, p_en, p_j2, p_hrst, p_short;  // Values the DUT samples next
    logic        en_val, j2_val, short_val;
    logic        m5_ir;           // IR column, or test-logic reset in REST
    logic [2:0]  m5_step;
    logic        m_tdo, m_oe;
    int          m2_st;
    int          m2_left;         // Position in the current field
    logic        m2_read, m2_dx, m2_pok;
    logic [1:0]  m2_sel;
    int          err_cnt, chk_cnt, test_err, test_cyc;
    int          n_shift_ir, n_shift_dr, n_upd, n_cap, n_sync, n_oe;
    logic [31:0] seed;

    dtm_ctrl i_dtm_ctrl (
        .tclk             (tclk),
        .trst_b           (trst_b),
        .dmi_hard_reset_i (dmi_hard_reset_i),
        .tap_en_i         (tap_en_i),
        .jtag2_sel_i      (jtag2_sel_i),
        .tms_i            (tms_i),
        .dmi_short_i      (dmi_short_i),
        .tdo_en_o         (tdo_en_o),
        .tms_oe_o         (tms_oe_o),
        .capture_ir_o     (capture_ir_o),
        .capture_dr_o     (capture_dr_o),
        .shift_ir_o       (shift_ir_o),
        .shift_dr_o       (shift_dr_o),
        .update_ir_o      (update_ir_o),
        .update_dr_o      (update_dr_o),
        .shift_par_o      (shift_par_o),
        .shift_sync_o     (shift_sync_o)
    );

    always #(T_CLK / 2) tclk = ~tclk;

    function automatic int field_len(input logic [1:0] sel, input logic short_mode);
        case (sel)
            2'b00:   return 5;
            2'b01:   return 1;
            2'b10:   return 32;
            default: return short_mode ? 34 : 50;  // Short DMI drops the address
        endcase
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = $urandom();
        return r[0];
    endfunction

    function automatic logic [1:0] rand_sel();
        logic [31:0] r;
        r = $urandom();
        return r[1:0];
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            test_err++;
            $display("mismatch %s exp %0h got %0h at %0t", name, exp, got, $time);
        end
    endtask

    // ========================================
    // Reference model, one rising edge
    // ========================================
    task automatic advance_model();
        if (p_hrst || p_j2) begin
            m5_ir   = 1'b1;
            m5_step = S_REST;
        end else begin
            case (m5_step)
                S_REST: begin
                    if (!m5_ir) begin
                        m5_step = p_tms ? S_SEL : S_REST;
                    end else if (p_en && !p_tms) begin
                        m5_ir = 1'b0;       // Reset to idle
                    end
                end
                S_SEL: begin
                    if (!p_tms) begin
                        m5_step = S_CAP;
                    end else if (!m5_ir) begin
                        m5_ir = 1'b1;
                    end else begin
                        m5_step = S_REST;   // Select-IR with TMS high resets
                    end
                end
                S_CAP, S_SHIFT: m5_step = p_tms ? S_EX1 : S_SHIFT;
                S_EX1:          m5_step = p_tms ? S_UPD : S_PAUSE;
                S_PAUSE:        m5_step = p_tms ? S_EX2 : S_PAUSE;
                S_EX2:          m5_step = p_tms ? S_UPD : S_SHIFT;
                default: begin
                    m5_ir   = 1'b0;
                    m5_step = p_tms ? S_SEL : S_REST;
                end
            endcase
        end
        // Output enable looks at the field being left
        if (p_hrst) begin
            m_oe    = 1'b0;
            m2_read = 1'b0;
        end else if (m2_st == P_TRN1 && m2_read) begin
            m_oe = 1'b1;
        end else if (m2_st == P_TRN2) begin
            m_oe = 1'b0;
        end
        if (p_hrst || !p_j2) begin
            m2_st = P_RESET;
        end else begin
            case (m2_st)
                P_RESET: m2_st = (p_en && p_tms) ? P_START : P_RESET;
                P_START: m2_st = p_tms ? P_START : P_RW;
                P_RW: begin
                    m2_read = p_tms;
                    m2_left = 0;
                    m2_st   = P_RS;
                end
                P_RS: begin
                    if (m2_left == 0) begin
                        m2_sel[0] = p_tms;
                        m2_left   = 1;
                    end else begin
                        m2_sel[1] = p_tms;
                        m2_st     = P_TRN1;
                    end
                end
                P_TRN1: begin
                    m2_left = field_len(m2_sel, p_short);
                    m2_dx   = 1'b0;
                    m2_st   = m2_read ? P_SYNC : P_DATA;
                end
                P_SYNC: m2_st = P_DATA;
                P_DATA: begin
                    m2_dx   = m2_dx ^ p_tms;
                    m2_left = m2_left - 1;
                    m2_st   = (m2_left == 0) ? P_PARITY : P_DATA;
                end
                P_PARITY: begin
                    m2_pok = m2_dx ^ p_tms;
                    m2_st  = P_TRN2;
                end
                default: m2_st = P_START;
            endcase
        end
    endtask

    task automatic check_outputs();
        logic sel_ir, c5, s5, u5, c2, s2, u2;
        sel_ir = (m2_sel == 2'b00);
        c5 = (m5_step == S_CAP);
        s5 = (m5_step == S_SHIFT);
        u5 = (m5_step == S_UPD);
        c2 = (m2_st == P_TRN1) && m2_read;
        s2 = (m2_st == P_DATA);
        u2 = (m2_st == P_TRN2) && m2_pok;
        compare("capture_ir_o", 32'(c5 && m5_ir || c2 && sel_ir), 32'(capture_ir_o));
        compare("capture_dr_o", 32'(c5 && !m5_ir || c2 && !sel_ir), 32'(capture_dr_o));
        compare("shift_ir_o", 32'(s5 && m5_ir || s2 && sel_ir), 32'(shift_ir_o));
        compare("shift_dr_o", 32'(s5 && !m5_ir || s2 && !sel_ir), 32'(shift_dr_o));
        compare("update_ir_o", 32'(u5 && m5_ir || u2 && sel_ir), 32'(update_ir_o));
        compare("update_dr_o", 32'(u5 && !m5_ir || u2 && !sel_ir), 32'(update_dr_o));
        compare("shift_par_o", 32'(m2_st == P_PARITY), 32'(shift_par_o));
        compare("shift_sync_o", 32'(m2_st == P_SYNC), 32'(shift_sync_o));
        compare("tms_oe_o", 32'(m_oe), 32'(tms_oe_o));
        n_shift_ir += int'(shift_ir_o);
        n_shift_dr += int'(shift_dr_o);
        n_upd      += int'(update_ir_o) + int'(update_dr_o);
        n_cap      += int'(capture_ir_o) + int'(capture_dr_o);
        n_sync     += int'(shift_sync_o);
        n_oe       += int'(tms_oe_o);
    endtask

    // One TCK cycle, outputs checked at the falling edge
    task automatic run_cycle(input logic tms, input logic hrst);
        @(posedge tclk);
        compare("tdo_en_o", 32'(m_tdo), 32'(tdo_en_o));
        advance_model();
        tms_i            <= tms;
        tap_en_i         <= en_val;
        jtag2_sel_i      <= j2_val;
        dmi_hard_reset_i <= hrst;
        dmi_short_i      <= short_val;
        p_tms   = tms;
        p_en    = en_val;
        p_j2    = j2_val;
        p_hrst  = hrst;
        p_short = short_val;
        @(negedge tclk);
        check_outputs();
        m_tdo = !p_hrst && (m5_step == S_SHIFT);
        test_cyc++;
    endtask

    // ========================================
    // Two-wire packet, cut short by a hard reset at data bit cut
    // ========================================
    task automatic send_packet(input logic rd, input logic [1:0] sel, input logic bad_par,
                               input int cut);
        int   len;
        logic bit_v, dx;
        len = field_len(sel, short_val);
        dx  = 1'b0;
        n_shift_ir = 0;
        n_shift_dr = 0;
        n_upd  = 0;
        n_cap  = 0;
        n_sync = 0;
        n_oe   = 0;
        run_cycle(1'b1, 1'b0);          // Idle high, machine waits in start
        run_cycle(1'b0, 1'b0);          // Start bit
        run_cycle(rd, 1'b0);
        run_cycle(sel[0], 1'b0);
        run_cycle(sel[1], 1'b0);
        run_cycle(rand_bit(), 1'b0);    // First turnaround
        if (rd) begin
            run_cycle(rand_bit(), 1'b0);
        end
        for (int i = 0; i < len; i++) begin
            bit_v = rand_bit();
            dx    = dx ^ bit_v;
            if (i == cut) begin
                run_cycle(bit_v, 1'b1);
                run_cycle(1'b1, 1'b0);
                compare("tms_oe_o", 0, 32'(tms_oe_o));
                compare("chain strobes", 0, 32'({capture_ir_o, capture_dr_o, shift_ir_o,
                        shift_dr_o, update_ir_o, update_dr_o, shift_par_o, shift_sync_o}));
                return;
            end
            run_cycle(bit_v, 1'b0);
        end
        run_cycle(!dx ^ bad_par, 1'b0); // Good parity gives odd weight
        run_cycle(rand_bit(), 1'b0);    // Second turnaround
        compare("update_ir_o", 32'(!bad_par && sel == 2'b00), 32'(update_ir_o));
        compare("update_dr_o", 32'(!bad_par && sel != 2'b00), 32'(update_dr_o));
        run_cycle(1'b1, 1'b0);
        compare("tms_oe_o", 0, 32'(tms_oe_o));
        compare("shift_ir_o count", (sel == 2'b00) ? len : 0, n_shift_ir);
        compare("shift_dr_o count", (sel != 2'b00) ? len : 0, n_shift_dr);
        compare("update count", bad_par ? 0 : 1, n_upd);
        compare("capture count", rd ? 1 : 0, n_cap);
        compare("shift_sync_o count", rd ? 1 : 0, n_sync);
        compare("tms_oe_o count", rd ? len + 3 : 0, n_oe);
    endtask

    task automatic start_test();
        test_err = 0;
        test_cyc = 0;
    endtask

    task automatic finish_test(input string name);
        $display("test %-16s cycles %0d errors %0d", name, test_cyc, test_err);
    endtask

    initial begin
        int         cut;
        logic [1:0] sel;
        seed   = $urandom(9);
        tclk   = 1'b0;
        trst_b = 1'b0;
        dmi_hard_reset_i = 1'b0;
        tap_en_i    = 1'b0;
        jtag2_sel_i = 1'b0;
        tms_i       = 1'b0;
        dmi_short_i = 1'b0;
        {p_tms, p_en, p_j2, p_hrst, p_short} = '0;
        {en_val, j2_val, short_val} = '0;
        m5_ir   = 1'b1;
        m5_step = S_REST;
        {m_tdo, m_oe, m2_read, m2_dx, m2_pok} = '0;
        m2_sel  = 2'b00;
        m2_st   = P_RESET;
        m2_left = 0;
        err_cnt = 0;
        chk_cnt = 0;
        repeat (10) @(posedge tclk);
        trst_b <= 1'b1;

        start_test();
        en_val = 1'b1;
        repeat (N_WALK) run_cycle(rand_bit(), 1'b0);
        finish_test("four-wire walk");

        start_test();
        repeat (5) run_cycle(1'b1, 1'b0);
        run_cycle(1'b0, 1'b0);
        run_cycle(1'b1, 1'b0);
        repeat (4) run_cycle(1'b0, 1'b0);   // Capture, then shift DR
        compare("shift_dr_o", 1, 32'(shift_dr_o));
        j2_val = 1'b1;
        repeat (5) begin
            run_cycle(1'b0, 1'b0);
        end
        compare("shift_dr_o", 0, 32'(shift_dr_o));
        finish_test("mode switch");

        start_test();
        for (int n = 0; n < N_PKT; n++) begin
            short_val = rand_bit();
            send_packet(1'b0, rand_sel(), 1'b0, -1);
        end
        finish_test("write packets");

        start_test();
        for (int n = 0; n < N_PKT; n++) begin
            short_val = rand_bit();
            send_packet(1'b1, rand_sel(), 1'b0, -1);
        end
        finish_test("read packets");

        start_test();
        for (int n = 0; n < N_PKT; n++) begin
            short_val = rand_bit();
            send_packet(rand_bit(), rand_sel(), 1'b1, -1);
        end
        finish_test("bad parity");

        start_test();
        for (int n = 0; n < N_PKT / 4; n++) begin
            short_val = rand_bit();
            sel = rand_sel();
            cut = $urandom_range(field_len(sel, short_val) - 1, 0);
            send_packet(1'b1, sel, 1'b0, cut);
            send_packet(rand_bit(), rand_sel(), 1'b0, -1);
        end
        finish_test("dmi hard reset");

        $display("checks %0d errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog over the summed test lengths plus margin
    initial begin
        #(WD_CYC * T_CLK);
        $display("timeout after %0d cycles, the tests did not finish", WD_CYC);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== source/dtm_ctrl.sv ====
// ========================================
// Debug transport control top
// Joins four-wire and two-wire paths
// onto one set of chain strobes
// ========================================
`timescale 1ns/1ps

module dtm_ctrl (
    input  logic tclk,
    input  logic trst_b,
    input  logic dmi_hard_reset_i,
    input  logic tap_en_i,
    input  logic jtag2_sel_i,
    input  logic tms_i,
    input  logic dmi_short_i,
    output logic tdo_en_o,
    output logic tms_oe_o,
    output logic capture_ir_o,
    output logic capture_dr_o,
    output logic shift_ir_o,
    output logic shift_dr_o,
    output logic update_ir_o,
    output logic update_dr_o,
    output logic shift_par_o,
    output logic shift_sync_o
);
    import dtm_pkg::*;

    // Four-wire strobes
    logic t5_capture_ir, t5_capture_dr;
    logic t5_shift_ir, t5_shift_dr;
    logic t5_update_ir, t5_update_dr;

    // Two-wire strobes
    logic t2_capture_ir, t2_capture_dr;
    logic t2_shift_ir, t2_shift_dr;
    logic t2_update_ir, t2_update_dr;

    // Sequencer to field datapath
    logic    st_rw, st_rs, st_trn1, st_data, st_parity;
    logic    rs_last, data_last, parity_ok;
    rs_sel_t rs_sel;

    tap5_fsm i_tap5_fsm (
        .tclk             (tclk),
        .trst_b           (trst_b),
        .dmi_hard_reset_i (dmi_hard_reset_i),
        .tap_en_i         (tap_en_i),
        .jtag2_sel_i      (jtag2_sel_i),
        .tms_i            (tms_i),
        .tdo_en_o         (tdo_en_o),
        .capture_ir_o     (t5_capture_ir),
        .capture_dr_o     (t5_capture_dr),
        .shift_ir_o       (t5_shift_ir),
        .shift_dr_o       (t5_shift_dr),
        .update_ir_o      (t5_update_ir),
        .update_dr_o      (t5_update_dr)
    );

    tap2_ctrl i_tap2_ctrl (
        .tclk             (tclk),
        .trst_b           (trst_b),
        .dmi_hard_reset_i (dmi_hard_reset_i),
        .tap_en_i         (tap_en_i),
        .jtag2_sel_i      (jtag2_sel_i),
        .tms_i            (tms_i),
        .rs_last_i        (rs_last),
        .data_last_i      (data_last),
        .rs_sel_i         (rs_sel),
        .parity_ok_i      (parity_ok),
        .st_rw_o          (st_rw),
        .st_rs_o          (st_rs),
        .st_trn1_o        (st_trn1),
        .st_data_o        (st_data),
        .st_parity_o      (st_parity),
        .tms_oe_o         (tms_oe_o),
        .capture_ir_o     (t2_capture_ir),
        .capture_dr_o     (t2_capture_dr),
        .shift_ir_o       (t2_shift_ir),
        .shift_dr_o       (t2_shift_dr),
        .update_ir_o      (t2_update_ir),
        .update_dr_o      (t2_update_dr),
        .shift_par_o      (shift_par_o),
        .shift_sync_o     (shift_sync_o)
    );

    tap2_field_regs i_tap2_field_regs (
        .tclk             (tclk),
        .trst_b           (trst_b),
        .dmi_hard_reset_i (dmi_hard_reset_i),
        .tms_i            (tms_i),
        .dmi_short_i      (dmi_short_i),
        .st_rw_i          (st_rw),
        .st_rs_i          (st_rs),
        .st_trn1_i        (st_trn1),
        .st_data_i        (st_data),
        .st_parity_i      (st_parity),
        .rs_last_o        (rs_last),
        .data_last_o      (data_last),
        .rs_sel_o         (rs_sel),
        .parity_ok_o      (parity_ok)
    );

    // ========================================
    // Chain strobe merge
    // ========================================
    // Idle machine sits in reset, so a plain OR is enough
    assign capture_ir_o = t5_capture_ir || t2_capture_ir;
    assign capture_dr_o = t5_capture_dr || t2_capture_dr;
    assign shift_ir_o   = t5_shift_ir   || t2_shift_ir;
    assign shift_dr_o   = t5_shift_dr   || t2_shift_dr;
    assign update_ir_o  = t5_update_ir  || t2_update_ir;
    assign update_dr_o  = t5_update_dr  || t2_update_dr;

endmodule

// ==== source/tap2_ctrl.sv ====
// ========================================
// Two-wire packet sequencer
// Walks the packet fields, owns the TMS
// output enable and the chain strobes
// ========================================
`timescale 1ns/1ps

module tap2_ctrl (
    input  logic            tclk,
    input  logic            trst_b,
    input  logic            dmi_hard_reset_i,
    input  logic            tap_en_i,
    input  logic            jtag2_sel_i,
    input  logic            tms_i,
    input  logic            rs_last_i,
    input  logic            data_last_i,
    input  dtm_pkg::rs_sel_t rs_sel_i,
    input  logic            parity_ok_i,
    output logic            st_rw_o,
    output logic            st_rs_o,
    output logic            st_trn1_o,
    output logic            st_data_o,
    output logic            st_parity_o,
    output logic            tms_oe_o,
    output logic            capture_ir_o,
    output logic            capture_dr_o,
    output logic            shift_ir_o,
    output logic            shift_dr_o,
    output logic            update_ir_o,
    output logic            update_dr_o,
    output logic            shift_par_o,
    output logic            shift_sync_o
);
    import dtm_pkg::*;

    tap2_state_t cur_st;
    tap2_state_t nxt_st;
    logic        read_q;    // Current packet is a read
    logic        st_trn2;
    logic        sel_ir;

    // ========================================
    // Packet state machine
    // ========================================
    always_ff @(posedge tclk or negedge trst_b) begin
        if (!trst_b) begin
            cur_st <= TAP2_RESET;
        end else if (dmi_hard_reset_i || !jtag2_sel_i) begin
            cur_st <= TAP2_RESET;
        end else begin
            cur_st <= nxt_st;
        end
    end

    always_comb begin
        case (cur_st)
            TAP2_RESET:  nxt_st = (tap_en_i && tms_i) ? TAP2_START : TAP2_RESET;
            TAP2_START:  nxt_st = tms_i ? TAP2_START : TAP2_RW;  // Start bit is low
            TAP2_RW:     nxt_st = TAP2_RS;
            TAP2_RS:     nxt_st = rs_last_i ? TAP2_TRN1 : TAP2_RS;
            TAP2_TRN1:   nxt_st = read_q ? TAP2_SYNC : TAP2_DATA;
            TAP2_SYNC:   nxt_st = TAP2_DATA;
            TAP2_DATA:   nxt_st = data_last_i ? TAP2_PARITY : TAP2_DATA;
            TAP2_PARITY: nxt_st = TAP2_TRN2;
            TAP2_TRN2:   nxt_st = TAP2_START;
            default:     nxt_st = TAP2_RESET;
        endcase
    end

    assign st_rw_o      = (cur_st == TAP2_RW);
    assign st_rs_o      = (cur_st == TAP2_RS);
    assign st_trn1_o    = (cur_st == TAP2_TRN1);
    assign st_data_o    = (cur_st == TAP2_DATA);
    assign st_parity_o  = (cur_st == TAP2_PARITY);
    assign st_trn2      = (cur_st == TAP2_TRN2);

    // TMS high in the RW field means read
    always_ff @(posedge tclk or negedge trst_b) begin
        if (!trst_b) begin
            read_q <= 1'b0;
        end else if (dmi_hard_reset_i) begin
            read_q <= 1'b0;
        end else if (st_rw_o) begin
            read_q <= tms_i;
        end
    end

    // ========================================
    // TMS output enable
    // ========================================
    // Held through a mode change, dropped only by resets
    always_ff @(posedge tclk or negedge trst_b) begin
        if (!trst_b) begin
            tms_oe_o <= 1'b0;
        end else if (dmi_hard_reset_i) begin
            tms_oe_o <= 1'b0;
        end else if (st_trn1_o && read_q) begin
            tms_oe_o <= 1'b1;   // Device drives from sync onwards
        end else if (st_trn2) begin
            tms_oe_o <= 1'b0;
        end
    end

    // Chain strobes
    assign sel_ir       = (rs_sel_i == RS_IR);

    assign capture_ir_o = st_trn1_o && read_q && sel_ir;
    assign capture_dr_o = st_trn1_o && read_q && !sel_ir;
    assign shift_ir_o   = st_data_o && sel_ir;
    assign shift_dr_o   = st_data_o && !sel_ir;
    assign update_ir_o  = st_trn2 && parity_ok_i && sel_ir;     // Good parity only
    assign update_dr_o  = st_trn2 && parity_ok_i && !sel_ir;
    assign shift_par_o  = st_parity_o;
    assign shift_sync_o = (cur_st == TAP2_SYNC);

    // Output enable stays low for the whole of a write packet
    a_oe_no_write: assert property (@(posedge tclk) disable iff (!trst_b)
        (!read_q && (st_rs_o || st_trn1_o || st_data_o || st_parity_o || st_trn2))
        |-> !tms_oe_o);

endmodule

// ==== source/tap2_field_regs.sv ====
// ========================================
// Two-wire packet field datapath
// Select shifter, data length counter
// and parity accumulator
// ========================================
`timescale 1ns/1ps

module tap2_field_regs (
    input  logic             tclk,
    input  logic             trst_b,
    input  logic             dmi_hard_reset_i,
    input  logic             tms_i,
    input  logic             dmi_short_i,
    input  logic             st_rw_i,
    input  logic             st_rs_i,
    input  logic             st_trn1_i,
    input  logic             st_data_i,
    input  logic             st_parity_i,
    output logic             rs_last_o,
    output logic             data_last_o,
    output dtm_pkg::rs_sel_t rs_sel_o,
    output logic             parity_ok_o
);
    import dtm_pkg::*;

    logic                  rs_cnt_q;      // Second select bit pending
    logic [DATA_CNT_W-1:0] data_cnt_q;
    logic [DATA_CNT_W-1:0] len_sel;
    logic                  parity_q;

    // ========================================
    // Register select
    // ========================================
    always_ff @(posedge tclk or negedge trst_b) begin
        if (!trst_b) begin
            rs_cnt_q <= 1'b0;
            rs_sel_o <= RS_IR;
        end else if (dmi_hard_reset_i || st_rw_i) begin
            rs_cnt_q <= 1'b0;
        end else if (st_rs_i) begin
            rs_cnt_q <= 1'b1;
            rs_sel_o <= rs_sel_t'({tms_i, rs_sel_o[1]});  // First bit lands in bit 0
        end
    end

    assign rs_last_o = rs_cnt_q;

    // Data field length from the select code
    always_comb begin
        case (rs_sel_o)
            RS_IR:     len_sel = LEN_IR;
            RS_DMIACC: len_sel = LEN_DMIACC;
            RS_NDMI:   len_sel = LEN_NDMI;
            default:   len_sel = dmi_short_i ? LEN_DMI_SHORT : LEN_DMI;
        endcase
    end

    // ========================================
    // Data counter and parity
    // ========================================
    always_ff @(posedge tclk or negedge trst_b) begin
        if (!trst_b) begin
            data_cnt_q <= '0;
        end else if (dmi_hard_reset_i) begin
            data_cnt_q <= '0;
        end else if (st_trn1_i) begin
            data_cnt_q <= len_sel - DATA_CNT_W'(1);   // Held through sync
        end else if (st_data_i) begin
            data_cnt_q <= data_cnt_q - DATA_CNT_W'(1);
        end
    end

    assign data_last_o = (data_cnt_q == '0);

    always_ff @(posedge tclk or negedge trst_b) begin
        if (!trst_b) begin
            parity_q <= 1'b1;
        end else if (dmi_hard_reset_i || st_rw_i) begin
            parity_q <= 1'b1;
        end else if (st_data_i || st_parity_i) begin
            parity_q <= parity_q ^ tms_i;
        end
    end

    // Data plus parity bit must have odd weight
    assign parity_ok_o = !parity_q;

    // Sequencer leaves the data field on the last count
    a_cnt_no_wrap: assert property (@(posedge tclk) disable iff (!trst_b)
        (st_data_i && data_cnt_q == '0) |=> !st_data_i);

endmodule

// ==== source/tap5_fsm.sv ====
// ========================================
// Four-wire TAP controller
// IEEE 1149.1 state graph, chain strobes
// and a falling-edge TDO enable
// ========================================
`timescale 1ns/1ps

module tap5_fsm (
    input  logic tclk,
    input  logic trst_b,
    input  logic dmi_hard_reset_i,
    input  logic tap_en_i,
    input  logic jtag2_sel_i,
    input  logic tms_i,
    output logic tdo_en_o,
    output logic capture_ir_o,
    output logic capture_dr_o,
    output logic shift_ir_o,
    output logic shift_dr_o,
    output logic update_ir_o,
    output logic update_dr_o
);
    import dtm_pkg::*;

    tap5_state_t cur_st;
    tap5_state_t nxt_st;

    // ========================================
    // State register
    // ========================================
    always_ff @(posedge tclk or negedge trst_b) begin
        if (!trst_b) begin
            cur_st <= TAP5_RESET;
        end else if (dmi_hard_reset_i || jtag2_sel_i) begin
            cur_st <= TAP5_RESET;       // Two-wire mode parks this machine
        end else begin
            cur_st <= nxt_st;
        end
    end

    always_comb begin
        case (cur_st)
            TAP5_RESET: begin
                // Only leaves reset when the TAP is enabled
                nxt_st = (tap_en_i && !tms_i) ? TAP5_IDLE : TAP5_RESET;
            end
            TAP5_IDLE:       nxt_st = tms_i ? TAP5_SEL_DR     : TAP5_IDLE;
            TAP5_SEL_DR:     nxt_st = tms_i ? TAP5_SEL_IR     : TAP5_CAPTURE_DR;
            TAP5_SEL_IR:     nxt_st = tms_i ? TAP5_RESET      : TAP5_CAPTURE_IR;
            TAP5_CAPTURE_IR: nxt_st = tms_i ? TAP5_EXIT1_IR   : TAP5_SHIFT_IR;
            TAP5_SHIFT_IR:   nxt_st = tms_i ? TAP5_EXIT1_IR   : TAP5_SHIFT_IR;
            TAP5_EXIT1_IR:   nxt_st = tms_i ? TAP5_UPDATE_IR  : TAP5_PAUSE_IR;
            TAP5_PAUSE_IR:   nxt_st = tms_i ? TAP5_EXIT2_IR   : TAP5_PAUSE_IR;
            TAP5_EXIT2_IR:   nxt_st = tms_i ? TAP5_UPDATE_IR  : TAP5_SHIFT_IR;
            TAP5_UPDATE_IR:  nxt_st = tms_i ? TAP5_SEL_DR     : TAP5_IDLE;
            TAP5_CAPTURE_DR: nxt_st = tms_i ? TAP5_EXIT1_DR   : TAP5_SHIFT_DR;
            TAP5_SHIFT_DR:   nxt_st = tms_i ? TAP5_EXIT1_DR   : TAP5_SHIFT_DR;
            TAP5_EXIT1_DR:   nxt_st = tms_i ? TAP5_UPDATE_DR  : TAP5_PAUSE_DR;
            TAP5_PAUSE_DR:   nxt_st = tms_i ? TAP5_EXIT2_DR   : TAP5_PAUSE_DR;
            TAP5_EXIT2_DR:   nxt_st = tms_i ? TAP5_UPDATE_DR  : TAP5_SHIFT_DR;
            TAP5_UPDATE_DR:  nxt_st = tms_i ? TAP5_SEL_DR     : TAP5_IDLE;
            default:         nxt_st = TAP5_RESET;
        endcase
    end

    // ========================================
    // Chain strobes
    // ========================================
    // Decoded from the registered state, one cycle per state visit
    assign capture_ir_o = (cur_st == TAP5_CAPTURE_IR);
    assign capture_dr_o = (cur_st == TAP5_CAPTURE_DR);
    assign shift_ir_o   = (cur_st == TAP5_SHIFT_IR);
    assign shift_dr_o   = (cur_st == TAP5_SHIFT_DR);
    assign update_ir_o  = (cur_st == TAP5_UPDATE_IR);
    assign update_dr_o  = (cur_st == TAP5_UPDATE_DR);

    // TDO driven half a cycle into a shift state
    always_ff @(negedge tclk or negedge trst_b) begin
        if (!trst_b) begin
            tdo_en_o <= 1'b0;
        end else if (dmi_hard_reset_i) begin
            tdo_en_o <= 1'b0;
        end else begin
            tdo_en_o <= shift_ir_o || shift_dr_o;
        end
    end

    // All 16 codes are TAP states, so only an unknown code is illegal
    a_state_legal: assert property (@(posedge tclk) disable iff (!trst_b)
        !$isunknown(cur_st));

endmodule

// ==== source/dtm_pkg.sv ====
// ========================================
// Debug transport control definitions
// State codes, select codes, field lengths
// ========================================
package dtm_pkg;

    // ========================================
    // Four-wire TAP states
    // ========================================
    typedef enum logic [3:0] {
        TAP5_RESET      = 4'b0000,
        TAP5_IDLE       = 4'b0001,
        TAP5_SEL_DR     = 4'b0011,
        TAP5_SEL_IR     = 4'b0010,
        TAP5_CAPTURE_IR = 4'b0110,
        TAP5_SHIFT_IR   = 4'b0100,
        TAP5_EXIT1_IR   = 4'b0101,
        TAP5_UPDATE_IR  = 4'b0111,
        TAP5_CAPTURE_DR = 4'b1011,
        TAP5_SHIFT_DR   = 4'b1010,
        TAP5_EXIT1_DR   = 4'b1000,
        TAP5_UPDATE_DR  = 4'b1001,
        TAP5_PAUSE_IR   = 4'b1101,
        TAP5_EXIT2_IR   = 4'b1111,
        TAP5_PAUSE_DR   = 4'b1100,
        TAP5_EXIT2_DR   = 4'b1110
    } tap5_state_t;

    // Two-wire packet states
    typedef enum logic [3:0] {
        TAP2_RESET  = 4'b0000,
        TAP2_START  = 4'b0001,
        TAP2_RW     = 4'b0010,
        TAP2_RS     = 4'b0011,
        TAP2_TRN1   = 4'b0100,
        TAP2_DATA   = 4'b0101,
        TAP2_SYNC   = 4'b0110,
        TAP2_PARITY = 4'b0111,
        TAP2_TRN2   = 4'b1000
    } tap2_state_t;

    typedef enum logic [1:0] {
        RS_IR     = 2'b00,  // Instruction register
        RS_DMIACC = 2'b01,  // DMI access
        RS_NDMI   = 2'b10,  // Other DR
        RS_DMI    = 2'b11
    } rs_sel_t;

    // ========================================
    // Field lengths in two-wire mode
    // ========================================
    localparam int DTM_ABITS  = 16;
    localparam int DATA_CNT_W = 8;

    localparam logic [DATA_CNT_W-1:0] LEN_IR        = DATA_CNT_W'(5);
    localparam logic [DATA_CNT_W-1:0] LEN_DMIACC    = DATA_CNT_W'(1);
    localparam logic [DATA_CNT_W-1:0] LEN_NDMI      = DATA_CNT_W'(32);
    localparam logic [DATA_CNT_W-1:0] LEN_DMI       = DATA_CNT_W'(DTM_ABITS + 34);
    localparam logic [DATA_CNT_W-1:0] LEN_DMI_SHORT = LEN_DMI - DATA_CNT_W'(DTM_ABITS);

endpackage
